/* logic/python_pkg.sv */
`default_nettype none

package python_pkg;

	// --------------------------------------------------
	// lane geometry
	// --------------------------------------------------
	// number of data lanes without the control lane
	localparam int CHANNEL_NUM = 4;
	// bits per word and clocks per slot
	localparam int DATA_WIDTH = 10;
	// width of the bit position counter
	localparam int SLOT_CNT_W = $clog2(DATA_WIDTH);
	// size fields of the frame config
	localparam int DIM_W = 12;

	// --------------------------------------------------
	// sync codes
	// --------------------------------------------------
	// frame start
	localparam logic [DATA_WIDTH-1:0] CODE_FS = 10'h2AA;
	// line start
	localparam logic [DATA_WIDTH-1:0] CODE_LS = 10'h0AA;
	// line end
	localparam logic [DATA_WIDTH-1:0] CODE_LE = 10'h12A;
	// frame end
	localparam logic [DATA_WIDTH-1:0] CODE_FE = 10'h3AA;
	// training word also sent while idle
	localparam logic [DATA_WIDTH-1:0] CODE_TR = 10'h3A6;

	// control word bit positions with all other bits zero
	localparam int CTRL_LV_BIT   = 0;
	localparam int CTRL_FV_BIT   = 1;
	localparam int CTRL_SYNC_BIT = 2;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	// run-time frame config
	typedef struct packed {
		logic [DIM_W-1:0] width_slots;
		logic [DIM_W-1:0] height;
		logic [DIM_W-1:0] line_hide;
		logic [DIM_W-1:0] frame_hide;
	} frame_cfg_t;

	// what one slot carries
	typedef enum logic [2:0] {
		IDLE, FS, LS, PIX, LE, FE, LHIDE, FHIDE
	} slot_kind_t;

	// one slot of the stream
	typedef struct packed {
		slot_kind_t       kind;
		logic [DIM_W-1:0] row;
		logic [DIM_W-1:0] slot;
	} slot_desc_t;

	// parallel load of the serializer
	typedef struct packed {
		logic [CHANNEL_NUM-1:0][DATA_WIDTH-1:0] data;
		logic [DATA_WIDTH-1:0]                  ctrl;
	} lane_word_t;

endpackage

`default_nettype wire

/* logic/frame_timing_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_timing_gen (
	input  wire                          clk_python,
	input  wire                          i_rst_n,
	input  wire                          i_slot_strobe,
	input  wire                          i_cfg_req,
	input  wire python_pkg::frame_cfg_t  i_cfg,
	output logic                         o_cfg_ack,
	output python_pkg::slot_desc_t       o_slot
);
	import python_pkg::*;

	// active config, only loaded at a frame boundary
	frame_cfg_t cfg_q;
	// end markers of the running counters
	logic       last_row;
	logic       last_pix;
	logic       last_lhide;
	logic       last_fhide;
	// current slot is the last one of the frame
	logic       frame_done;
	// request taken at this strobe
	logic       cfg_take;
	slot_desc_t slot_next;

	// first slot of a frame
	// training first or straight to FS without frame_hide
	function automatic slot_desc_t frame_first(input frame_cfg_t cfg);
		slot_desc_t s;
		s.kind = (cfg.frame_hide != '0) ? FHIDE : FS;
		s.row  = '0;
		s.slot = '0;
		return s;
	endfunction

	// --------------------------------------------------
	// slot sequencing
	// --------------------------------------------------
	assign last_row   = (o_slot.row == cfg_q.height - 1'b1);
	assign last_pix   = (o_slot.slot == cfg_q.width_slots - 1'b1);
	assign last_lhide = (o_slot.slot == cfg_q.line_hide - 1'b1);
	assign last_fhide = (o_slot.slot == cfg_q.frame_hide - 1'b1);

	// FE closes the frame only without line hide
	assign frame_done = ((o_slot.kind == FE) && (cfg_q.line_hide == '0)) ||
		((o_slot.kind == LHIDE) && last_row && last_lhide);

	// accept only in idle or at frame end and only on a fresh req
	assign cfg_take = i_cfg_req && !o_cfg_ack && ((o_slot.kind == IDLE) || frame_done);

	always_comb begin
		slot_next = o_slot;
		case (o_slot.kind)
			FHIDE: begin
				if (last_fhide) begin
					slot_next.kind = FS;
					slot_next.slot = '0;
				end else begin
					slot_next.slot = o_slot.slot + 1'b1;
				end
			end
			FS, LS: begin
				slot_next.kind = PIX;
				slot_next.slot = '0;
			end
			PIX: begin
				if (last_pix) begin
					slot_next.kind = last_row ? FE : LE;
					slot_next.slot = '0;
				end else begin
					slot_next.slot = o_slot.slot + 1'b1;
				end
			end
			LE, FE: begin
				if (cfg_q.line_hide != '0) begin
					slot_next.kind = LHIDE;
					slot_next.slot = '0;
				end else if (o_slot.kind == LE) begin
					slot_next.kind = LS;
					slot_next.row  = o_slot.row + 1'b1;
					slot_next.slot = '0;
				end else begin
					// repeat with the active config
					slot_next = frame_first(cfg_q);
				end
			end
			LHIDE: begin
				if (!last_lhide) begin
					slot_next.slot = o_slot.slot + 1'b1;
				end else if (last_row) begin
					slot_next = frame_first(cfg_q);
				end else begin
					slot_next.kind = LS;
					slot_next.row  = o_slot.row + 1'b1;
					slot_next.slot = '0;
				end
			end
			// idle waits for a config
			default: slot_next = o_slot;
		endcase
	end

	// --------------------------------------------------
	// state and handshake
	// --------------------------------------------------
	always_ff @(posedge clk_python or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cfg_ack   <= 1'b0;
			o_slot.kind <= IDLE;
			o_slot.row  <= '0;
			o_slot.slot <= '0;
		end else if (i_slot_strobe) begin
			if (cfg_take) begin
				o_cfg_ack <= 1'b1;
				o_slot    <= frame_first(i_cfg);
			end else begin
				o_slot <= slot_next;
				// ack drops once req is gone
				if (o_cfg_ack && !i_cfg_req) begin
					o_cfg_ack <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_python) begin
		if (i_slot_strobe && cfg_take) begin
			cfg_q <= i_cfg;
		end
	end

endmodule

`default_nettype wire

/* logic/sync_word_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_word_mux (
	input  wire python_pkg::slot_desc_t  i_slot,
	output python_pkg::lane_word_t       o_words
);
	import python_pkg::*;

	// ramp value of lane 0
	logic [DATA_WIDTH-1:0] pix_base;
	// code for the sync slot kinds
	logic [DATA_WIDTH-1:0] sync_code;

	// row*64 + slot*4 wrapped to the word width
	assign pix_base = DATA_WIDTH'({i_slot.row, 6'b0} + {i_slot.slot, 2'b0});

	// --------------------------------------------------
	// sync code select
	// --------------------------------------------------
	always_comb begin
		case (i_slot.kind)
			FS:      sync_code = CODE_FS;
			LS:      sync_code = CODE_LS;
			LE:      sync_code = CODE_LE;
			FE:      sync_code = CODE_FE;
			default: sync_code = CODE_TR;
		endcase
	end

	// --------------------------------------------------
	// lane words and control word
	// --------------------------------------------------
	always_comb begin
		// training and zero control by default
		o_words.data = {CHANNEL_NUM{CODE_TR}};
		o_words.ctrl = '0;
		case (i_slot.kind)
			PIX: begin
				// each lane one step up the ramp
				for (int c = 0; c < CHANNEL_NUM; c++) begin
					o_words.data[c] = pix_base + DATA_WIDTH'(c);
				end
				o_words.ctrl[CTRL_LV_BIT] = 1'b1;
				o_words.ctrl[CTRL_FV_BIT] = 1'b1;
			end
			FS, FE: begin
				o_words.data = {CHANNEL_NUM{sync_code}};
				o_words.ctrl[CTRL_SYNC_BIT] = 1'b1;
				o_words.ctrl[CTRL_FV_BIT]   = 1'b1;
			end
			LS, LE: begin
				// line codes also carry LV
				o_words.data = {CHANNEL_NUM{sync_code}};
				o_words.ctrl[CTRL_SYNC_BIT] = 1'b1;
				o_words.ctrl[CTRL_FV_BIT]   = 1'b1;
				o_words.ctrl[CTRL_LV_BIT]   = 1'b1;
			end
			LHIDE: begin
				// still inside the frame
				o_words.ctrl[CTRL_FV_BIT] = 1'b1;
			end
			default: begin
				o_words.ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/lane_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_serializer (
	input  wire                                 clk_python,
	input  wire                                 i_rst_n,
	input  wire python_pkg::lane_word_t         i_words,
	output logic                                o_slot_strobe,
	output logic [python_pkg::CHANNEL_NUM-1:0]  o_data,
	output logic                                o_ctrl
);
	import python_pkg::*;

	// bit position inside the slot
	logic [SLOT_CNT_W-1:0] bit_cnt;
	// four data shifters plus the control shifter
	lane_word_t            shift_q;

	// --------------------------------------------------
	// bit-slot counter
	// --------------------------------------------------
	always_ff @(posedge clk_python or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bit_cnt <= '0;
		end else if (o_slot_strobe) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// last clock of the slot
	assign o_slot_strobe = (bit_cnt == SLOT_CNT_W'(DATA_WIDTH - 1));

	// --------------------------------------------------
	// shift registers, MSB first
	// --------------------------------------------------
	always_ff @(posedge clk_python or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shift_q.data <= {CHANNEL_NUM{CODE_TR}};
			shift_q.ctrl <= '0;
		end else if (o_slot_strobe) begin
			// next word goes out in the following slot
			shift_q <= i_words;
		end else begin
			for (int c = 0; c < CHANNEL_NUM; c++) begin
				shift_q.data[c] <= {shift_q.data[c][DATA_WIDTH-2:0], 1'b0};
			end
			shift_q.ctrl <= {shift_q.ctrl[DATA_WIDTH-2:0], 1'b0};
		end
	end

	// top bit of each lane
	always_comb begin
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			o_data[c] = shift_q.data[c][DATA_WIDTH-1];
		end
	end
	assign o_ctrl = shift_q.ctrl[DATA_WIDTH-1];

endmodule

`default_nettype wire

/* logic/python_lvds_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module python_lvds_tx (
	input  wire                                 clk_python,
	input  wire                                 i_rst_n,
	input  wire                                 i_cfg_req,
	input  wire python_pkg::frame_cfg_t         i_cfg,
	output logic                                o_cfg_ack,
	output logic [python_pkg::CHANNEL_NUM-1:0]  o_data,
	output logic                                o_ctrl
);
	import python_pkg::*;

	// --------------------------------------------------
	// internal links
	// --------------------------------------------------
	// slot due next, from the timing generator
	slot_desc_t slot;
	// words for that slot
	lane_word_t words;
	// slot boundary from the serializer
	logic       slot_strobe;

	// frame and line sequencing
	frame_timing_gen u_frame_timing_gen (
		.clk_python    (clk_python),
		.i_rst_n       (i_rst_n),
		.i_slot_strobe (slot_strobe),
		.i_cfg_req     (i_cfg_req),
		.i_cfg         (i_cfg),
		.o_cfg_ack     (o_cfg_ack),
		.o_slot        (slot)
	);

	// slot to lane words
	sync_word_mux u_sync_word_mux (
		.i_slot  (slot),
		.o_words (words)
	);

	// serial out
	lane_serializer u_lane_serializer (
		.clk_python    (clk_python),
		.i_rst_n       (i_rst_n),
		.i_words       (words),
		.o_slot_strobe (slot_strobe),
		.o_data        (o_data),
		.o_ctrl        (o_ctrl)
	);

endmodule

`default_nettype wire

/* dv/python_ref_model.svh */
`ifndef PYTHON_REF_MODEL_SVH
`define PYTHON_REF_MODEL_SVH

// --------------------------------------------------
// word rule per slot kind
// --------------------------------------------------
function automatic lane_word_t expected_slot(input slot_kind_t kind,
		input logic [DIM_W-1:0] row, input logic [DIM_W-1:0] slot);
	lane_word_t            w;
	logic [DATA_WIDTH-1:0] code;
	w.data = {CHANNEL_NUM{CODE_TR}};
	w.ctrl = '0;
	code = (kind == FS) ? CODE_FS : (kind == LS) ? CODE_LS :
		(kind == LE) ? CODE_LE : CODE_FE;
	if (kind == PIX) begin
		// ramp one step per lane wrapping at 2^DATA_WIDTH
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			w.data[c] = DATA_WIDTH'((int'(row) * 64 + int'(slot) * 4 + c) % (1 << DATA_WIDTH));
		end
		w.ctrl[CTRL_LV_BIT] = 1'b1;
		w.ctrl[CTRL_FV_BIT] = 1'b1;
	end else if (kind inside {FS, LS, LE, FE}) begin
		w.data = {CHANNEL_NUM{code}};
		w.ctrl[CTRL_SYNC_BIT] = 1'b1;
		w.ctrl[CTRL_FV_BIT]   = 1'b1;
		// lv only on the line codes
		w.ctrl[CTRL_LV_BIT]   = (kind == LS) || (kind == LE);
	end else if (kind == LHIDE) begin
		w.ctrl[CTRL_FV_BIT] = 1'b1;
	end
	return w;
endfunction

// --------------------------------------------------
// stream position decoding
// --------------------------------------------------
// slots in one frame of a config
function automatic int frame_len(input frame_cfg_t cfg);
	return int'(cfg.frame_hide) +
		int'(cfg.height) * (int'(cfg.width_slots) + 2 + int'(cfg.line_hide));
endfunction

// slot at index idx of a frame
function automatic slot_desc_t frame_slot(input frame_cfg_t cfg, input int idx);
	slot_desc_t s;
	int         w;
	int         line_len;
	int         i;
	int         p;
	w = int'(cfg.width_slots);
	line_len = w + 2 + int'(cfg.line_hide);
	i = idx - int'(cfg.frame_hide);
	p = i % line_len;
	s = '0;
	if (i < 0) begin
		s.kind = FHIDE;
		s.slot = DIM_W'(idx);
	end else begin
		s.row = DIM_W'(i / line_len);
		// start code, pixels, end code, then line training
		if (p == 0) begin
			s.kind = (i / line_len == 0) ? FS : LS;
		end else if (p <= w) begin
			s.kind = PIX;
			s.slot = DIM_W'(p - 1);
		end else if (p == w + 1) begin
			s.kind = (i / line_len == int'(cfg.height) - 1) ? FE : LE;
		end else begin
			s.kind = LHIDE;
			s.slot = DIM_W'(p - w - 2);
		end
	end
	return s;
endfunction

// --------------------------------------------------
// compare tasks
// --------------------------------------------------
task automatic check_word(input string name, input lane_word_t exp_w, input lane_word_t act_w);
	if (act_w !== exp_w) begin
		word_errs++;
		$display("mismatch %s expected %h actual %h", name, exp_w, act_w);
	end
endtask

task automatic check_ack(input string name, input logic exp_a, input logic act_a);
	if (act_a !== exp_a) begin
		ack_errs++;
		$display("mismatch %s cfg_ack expected %b actual %b", name, exp_a, act_a);
	end
endtask

`endif

/* dv/tb_python_lvds_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_python_lvds_tx;
	import python_pkg::*;

	logic                   clk_python;
	logic                   i_rst_n;
	logic                   i_cfg_req;
	frame_cfg_t             i_cfg;
	logic                   o_cfg_ack;
	logic [CHANNEL_NUM-1:0] o_data;
	logic                   o_ctrl;

	// error counts per kind of result
	int         word_errs = 0;
	int         ack_errs = 0;
	int         misc_errs = 0;
	string      phase = "idle";
	int         req_cnt = 0;
	int         acc_cnt = 0;
	int         limit_ns = 0;
	frame_cfg_t cfg_list [4];
	// deserializer
	lane_word_t rx_word;
	int         rx_bit = 0;
	lane_word_t rx_q [$];
	logic       ack_q [$];
	// decoder walk
	frame_cfg_t act_cfg;
	frame_cfg_t pend_cfg;
	bit         act_ok = 1'b0;
	bit         pend_ok = 1'b0;
	int         slot_idx = 0;
	int         start_at = 0;
	int         pos = 0;
	logic       prev_ack = 1'b0;
	lane_word_t got_w;
	logic       got_a;
	slot_desc_t want;

	`include "python_ref_model.svh"

	python_lvds_tx i_dut (
		.clk_python (clk_python),
		.i_rst_n    (i_rst_n),
		.i_cfg_req  (i_cfg_req),
		.i_cfg      (i_cfg),
		.o_cfg_ack  (o_cfg_ack),
		.o_data     (o_data),
		.o_ctrl     (o_ctrl)
	);

	// 20 ns period
	always #10 clk_python = ~clk_python;

	// --------------------------------------------------
	// deserializer sampling mid-bit
	// --------------------------------------------------
	always @(negedge clk_python) begin
		if (i_rst_n) begin
			for (int c = 0; c < CHANNEL_NUM; c++) begin
				rx_word.data[c] = {rx_word.data[c][DATA_WIDTH-2:0], o_data[c]};
			end
			rx_word.ctrl = {rx_word.ctrl[DATA_WIDTH-2:0], o_ctrl};
			rx_bit++;
			// whole word in with ack flat across the slot
			if (rx_bit == DATA_WIDTH) begin
				rx_bit = 0;
				rx_q.push_back(rx_word);
				ack_q.push_back(o_cfg_ack);
			end
		end
	end

	// --------------------------------------------------
	// decoder and checker
	// --------------------------------------------------
	always begin
		wait (rx_q.size() != 0);
		got_w = rx_q.pop_front();
		got_a = ack_q.pop_front();
		// new frame starts the slot after ack is seen
		if (pend_ok && slot_idx == start_at) begin
			act_cfg = pend_cfg;
			act_ok = 1'b1;
			pend_ok = 1'b0;
			pos = 0;
		end else if (act_ok) begin
			pos = (pos + 1) % frame_len(act_cfg);
		end
		want = '0;
		if (act_ok) begin
			want = frame_slot(act_cfg, pos);
		end
		check_word($sformatf("%s slot %0d %s", phase, slot_idx, want.kind.name()),
			expected_slot(want.kind, want.row, want.slot), got_w);
		if (got_a && !prev_ack) begin
			acc_cnt++;
			// only idle or the last slot of a frame may come before a new config
			if (act_ok && pos != frame_len(act_cfg) - 1) begin
				misc_errs++;
				$display("error: %s config accepted in mid-frame at slot %0d", phase, slot_idx);
			end
			pend_cfg = i_cfg;
			pend_ok = 1'b1;
			start_at = slot_idx + 1;
		end
		prev_ack = got_a;
		slot_idx++;
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	// one clock then 1 ns past the edge
	task automatic tick();
		@(posedge clk_python);
		#1;
	endtask

	task automatic wait_slots(input int n);
		repeat (n * DATA_WIDTH) tick();
	endtask

	function automatic frame_cfg_t make_cfg(input int w, input int h, input int lh, input int fh);
		frame_cfg_t cfg;
		cfg.width_slots = DIM_W'(w);
		cfg.height      = DIM_W'(h);
		cfg.line_hide   = DIM_W'(lh);
		cfg.frame_hide  = DIM_W'(fh);
		return cfg;
	endfunction

	// full four-phase handshake then two frames
	task automatic run_config(input string name, input frame_cfg_t cfg);
		int waited;
		waited = 0;
		phase = name;
		i_cfg = cfg;
		i_cfg_req = 1'b1;
		req_cnt++;
		tick();
		while (!o_cfg_ack && waited < 64 * DATA_WIDTH) begin
			tick();
			waited++;
		end
		if (!o_cfg_ack) begin
			misc_errs++;
			$display("error: %s request was never acknowledged", name);
		end
		// ack holds while req is up
		for (int s = 0; s < 2; s++) begin
			wait_slots(1);
			check_ack({name, " ack_hold"}, 1'b1, o_cfg_ack);
		end
		i_cfg_req = 1'b0;
		// ack low right after the next slot strobe
		wait_slots(1);
		check_ack({name, " ack_release"}, 1'b0, o_cfg_ack);
		wait_slots(2);
		check_ack({name, " no_reaccept"}, 1'b0, o_cfg_ack);
		wait_slots(2 * frame_len(cfg));
	endtask

	initial begin
		int budget;
		clk_python = 1'b0;
		i_rst_n = 1'b0;
		i_cfg_req = 1'b0;
		i_cfg = '0;
		void'($urandom(32'h6200_be0a));
		cfg_list[0] = make_cfg(3, 2, 1, 2);
		for (int n = 1; n < 4; n++) begin
			cfg_list[n] = make_cfg($urandom_range(4, 1), $urandom_range(3, 1),
				$urandom_range(2, 0), $urandom_range(2, 0));
		end
		// watchdog limit from the frame lengths
		budget = 16;
		foreach (cfg_list[n]) begin
			budget += 3 * frame_len(cfg_list[n]) + 8;
		end
		limit_ns = budget * DATA_WIDTH * 20 + 2000;
		repeat (3) @(posedge clk_python);
		#1;
		i_rst_n = 1'b1;
		for (int s = 0; s < 5; s++) begin
			wait_slots(1);
			check_ack("idle", 1'b0, o_cfg_ack);
		end
		run_config("fixed_cfg", cfg_list[0]);
		for (int n = 1; n < 4; n++) begin
			run_config($sformatf("random_cfg_%0d", n), cfg_list[n]);
		end
		if (acc_cnt != req_cnt) begin
			misc_errs++;
			$display("error: %0d acknowledges seen for %0d requests", acc_cnt, req_cnt);
		end
		$display("errors: word %0d, ack %0d, other %0d", word_errs, ack_errs, misc_errs);
		if (word_errs + ack_errs + misc_errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("error: timeout, the run did not end within %0d ns", limit_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
logic/python_pkg.sv
logic/frame_timing_gen.sv
logic/sync_word_mux.sv
logic/lane_serializer.sv
logic/python_lvds_tx.sv
dv/tb_python_lvds_tx.sv
